// File: design/alu_rx_pkg.sv
`default_nettype none

package alu_rx_pkg;

    ////////////////////////////////////////
    // Serial link timing
    ////////////////////////////////////////

    // Clock cycles per bit on the line
    localparam int OVERSAMPLE = 16;
    // Start edge to middle of the start bit
    localparam int HALF_BIT   = 8;

    ////////////////////////////////////////
    // Packet layout
    ////////////////////////////////////////

    localparam int DATA_W      = 32;
    localparam int PAYLOAD_W   = 8;
    localparam int DATA_FRAMES = 8;
    localparam int OPCODE_W    = 3;
    localparam int CRC_W       = 4;
    // x^4 + x + 1
    localparam logic [CRC_W-1:0] CRC_POLY = 4'h3;
    // Operands, one marker bit and the opcode
    localparam int CRC_MSG_W   = 2 * DATA_W + 1 + OPCODE_W;

    // Frame control states
    localparam logic [2:0] ST_START   = 3'd0;
    localparam logic [2:0] ST_TYPE    = 3'd1;
    localparam logic [2:0] ST_PAYLOAD = 3'd2;
    localparam logic [2:0] ST_STOP    = 3'd3;
    localparam logic [2:0] ST_CHECK   = 3'd4;

    // Command payload, first bit on the line is the flag
    typedef struct packed {
        logic                flag;
        logic [OPCODE_W-1:0] opcode;
        logic [CRC_W-1:0]    crc;
    } cmd_fields_t;

    // One captured payload byte, read as data or as a command
    typedef union packed {
        logic [PAYLOAD_W-1:0] data;
        cmd_fields_t          cmd;
    } payload_u;

endpackage

`default_nettype wire

// File: design/alu_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module alu_rx_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              serial_in,
    output logic [alu_rx_pkg::DATA_W-1:0]    data_out_a,
    output logic [alu_rx_pkg::DATA_W-1:0]    data_out_b,
    output logic [alu_rx_pkg::OPCODE_W-1:0]  opcode,
    output logic                             ack,
    output logic                             frame_error,
    output logic                             crc_error
);

    logic                            bit_strobe;
    logic                            bit_value;
    logic                            hunt;
    logic                            shift_en;
    logic                            byte_done;
    logic                            check;
    logic                            publish;
    logic                            crc_ok;
    alu_rx_pkg::payload_u            payload;
    logic [alu_rx_pkg::DATA_W-1:0]   operand_a;
    logic [alu_rx_pkg::DATA_W-1:0]   operand_b;

    ////////////////////////////////////////
    // Bit timing
    ////////////////////////////////////////

    rx_bit_timer i_bit_timer (
        .clk        (clk),
        .rst        (rst),
        .serial_in  (serial_in),
        .hunt       (hunt),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value)
    );

    ////////////////////////////////////////
    // Frame and packet control
    ////////////////////////////////////////

    rx_frame_ctrl i_frame_ctrl (
        .clk         (clk),
        .rst         (rst),
        .bit_strobe  (bit_strobe),
        .bit_value   (bit_value),
        .payload     (payload),
        .crc_ok      (crc_ok),
        .hunt        (hunt),
        .shift_en    (shift_en),
        .byte_done   (byte_done),
        .check       (check),
        .publish     (publish),
        .ack         (ack),
        .frame_error (frame_error),
        .crc_error   (crc_error)
    );

    // Operand capture and result registers
    rx_packet_assembler i_packet_assembler (
        .clk        (clk),
        .rst        (rst),
        .bit_value  (bit_value),
        .shift_en   (shift_en),
        .byte_done  (byte_done),
        .publish    (publish),
        .payload    (payload),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .data_out_a (data_out_a),
        .data_out_b (data_out_b),
        .opcode     (opcode)
    );

    rx_crc4_check i_crc4_check (
        .clk       (clk),
        .rst       (rst),
        .check     (check),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .payload   (payload),
        .crc_ok    (crc_ok)
    );

endmodule

`default_nettype wire

// File: design/rx_bit_timer.sv
`timescale 1ns/100ps
`default_nettype none

module rx_bit_timer (
    input  wire  clk,
    input  wire  rst,
    input  wire  serial_in,
    input  wire  hunt,
    output logic bit_strobe,
    output logic bit_value
);

    logic       sync_q1;
    logic       sync_q2;
    logic       active;
    logic       first;
    logic [3:0] phase;
    logic [3:0] phase_end;

    // Two flop synchroniser, idles high like the line
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
        end
        else
        begin
            sync_q1 <= serial_in;
            sync_q2 <= sync_q1;
        end
    end

    // Half a bit to the start bit middle, then a full bit each
    assign phase_end  = first ? 4'(alu_rx_pkg::HALF_BIT - 1) : 4'(alu_rx_pkg::OVERSAMPLE - 1);
    assign bit_strobe = active && (phase == phase_end);
    assign bit_value  = sync_q2;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            active <= 1'b0;
            first  <= 1'b0;
            phase  <= '0;
        end
        else if (!active)
        begin
            // Look for a falling line while hunting
            if (hunt && !sync_q2)
            begin
                active <= 1'b1;
                first  <= 1'b1;
                phase  <= '0;
            end
        end
        else if (hunt && !first)
        begin
            // Frame over or start rejected, go back to hunting
            active <= 1'b0;
        end
        else if (bit_strobe)
        begin
            phase <= '0;
            first <= 1'b0;
        end
        else
        begin
            phase <= phase + 4'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/rx_crc4_check.sv
`timescale 1ns/100ps
`default_nettype none

module rx_crc4_check (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           check,
    input  wire [alu_rx_pkg::DATA_W-1:0]  operand_a,
    input  wire [alu_rx_pkg::DATA_W-1:0]  operand_b,
    input  alu_rx_pkg::payload_u          payload,
    output logic                          crc_ok
);

    logic [alu_rx_pkg::CRC_MSG_W-1:0] message;

    // Serial CRC, message MSB first, zero seed
    function automatic logic [alu_rx_pkg::CRC_W-1:0] crc4_calc(
        input logic [alu_rx_pkg::CRC_MSG_W-1:0] msg
    );
        logic [alu_rx_pkg::CRC_W-1:0] crc;
        logic                         feedback;
        crc = '0;
        for (int i = alu_rx_pkg::CRC_MSG_W - 1; i >= 0; i--)
        begin
            feedback = crc[alu_rx_pkg::CRC_W-1] ^ msg[i];
            crc      = {crc[alu_rx_pkg::CRC_W-2:0], 1'b0};
            if (feedback)
            begin
                crc = crc ^ alu_rx_pkg::CRC_POLY;
            end
        end
        return crc;
    endfunction

    // Constant 1 sits between B and the opcode
    assign message = {operand_a, operand_b, 1'b1, payload.cmd.opcode};

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            crc_ok <= 1'b0;
        end
        else if (check)
        begin
            crc_ok <= (crc4_calc(message) == payload.cmd.crc);
        end
    end

endmodule

`default_nettype wire

// File: design/rx_frame_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_ctrl (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  bit_strobe,
    input  wire                  bit_value,
    input  alu_rx_pkg::payload_u payload,
    input  wire                  crc_ok,
    output logic                 hunt,
    output logic                 shift_en,
    output logic                 byte_done,
    output logic                 check,
    output logic                 publish,
    output logic                 ack,
    output logic                 frame_error,
    output logic                 crc_error
);

    logic [2:0] state;
    logic [2:0] bit_idx;
    logic [3:0] frame_cnt;
    logic       cmd_slot;
    logic       stop_bad;

    // Ninth frame of the packet carries the command
    assign cmd_slot = (frame_cnt == 4'(alu_rx_pkg::DATA_FRAMES));
    assign stop_bad = !bit_value || (cmd_slot && payload.cmd.flag);

    // Outputs load together with ack, so publish follows crc_ok directly
    assign publish = (state == alu_rx_pkg::ST_CHECK) && !check && crc_ok;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state       <= alu_rx_pkg::ST_START;
            bit_idx     <= '0;
            frame_cnt   <= '0;
            hunt        <= 1'b1;
            shift_en    <= 1'b0;
            byte_done   <= 1'b0;
            check       <= 1'b0;
            ack         <= 1'b0;
            frame_error <= 1'b0;
            crc_error   <= 1'b0;
        end
        else
        begin
            shift_en    <= 1'b0;
            byte_done   <= 1'b0;
            check       <= 1'b0;
            ack         <= 1'b0;
            frame_error <= 1'b0;
            crc_error   <= 1'b0;

            case (state)
                alu_rx_pkg::ST_START:
                begin
                    // A high start sample is a glitch, keep hunting
                    if (bit_strobe && !bit_value)
                    begin
                        state <= alu_rx_pkg::ST_TYPE;
                        hunt  <= 1'b0;
                    end
                end

                alu_rx_pkg::ST_TYPE:
                begin
                    if (bit_strobe)
                    begin
                        if (bit_value == cmd_slot)
                        begin
                            state   <= alu_rx_pkg::ST_PAYLOAD;
                            bit_idx <= '0;
                        end
                        else
                        begin
                            frame_error <= 1'b1;
                            frame_cnt   <= '0;
                            hunt        <= 1'b1;
                            state       <= alu_rx_pkg::ST_START;
                        end
                    end
                end

                alu_rx_pkg::ST_PAYLOAD:
                begin
                    if (bit_strobe)
                    begin
                        shift_en <= 1'b1;
                        bit_idx  <= bit_idx + 3'd1;
                        if (bit_idx == 3'(alu_rx_pkg::PAYLOAD_W - 1))
                        begin
                            state <= alu_rx_pkg::ST_STOP;
                        end
                    end
                end

                alu_rx_pkg::ST_STOP:
                begin
                    if (bit_strobe)
                    begin
                        hunt <= 1'b1;
                        if (stop_bad)
                        begin
                            frame_error <= 1'b1;
                            frame_cnt   <= '0;
                            state       <= alu_rx_pkg::ST_START;
                        end
                        else if (cmd_slot)
                        begin
                            check <= 1'b1;
                            state <= alu_rx_pkg::ST_CHECK;
                        end
                        else
                        begin
                            byte_done <= 1'b1;
                            frame_cnt <= frame_cnt + 4'd1;
                            state     <= alu_rx_pkg::ST_START;
                        end
                    end
                end

                alu_rx_pkg::ST_CHECK:
                begin
                    // First cycle here the CRC result is still being registered
                    if (!check)
                    begin
                        ack       <= crc_ok;
                        crc_error <= !crc_ok;
                        frame_cnt <= '0;
                        state     <= alu_rx_pkg::ST_START;
                    end
                end

                default:
                begin
                    hunt  <= 1'b1;
                    state <= alu_rx_pkg::ST_START;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rx_packet_assembler.sv
`timescale 1ns/100ps
`default_nettype none

module rx_packet_assembler (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                bit_value,
    input  wire                                shift_en,
    input  wire                                byte_done,
    input  wire                                publish,
    output alu_rx_pkg::payload_u               payload,
    output logic [alu_rx_pkg::DATA_W-1:0]      operand_a,
    output logic [alu_rx_pkg::DATA_W-1:0]      operand_b,
    output logic [alu_rx_pkg::DATA_W-1:0]      data_out_a,
    output logic [alu_rx_pkg::DATA_W-1:0]      data_out_b,
    output logic [alu_rx_pkg::OPCODE_W-1:0]    opcode
);

    // A in the upper half, B in the lower half
    logic [2*alu_rx_pkg::DATA_W-1:0] operand_store;

    ////////////////////////////////////////
    // Payload and operand shifting
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        // MSB arrives first
        if (shift_en)
        begin
            payload.data <= {payload.data[alu_rx_pkg::PAYLOAD_W-2:0], bit_value};
        end
        if (byte_done)
        begin
            operand_store <= {operand_store[2*alu_rx_pkg::DATA_W-alu_rx_pkg::PAYLOAD_W-1:0],
                              payload.data};
        end
    end

    assign operand_a = operand_store[2*alu_rx_pkg::DATA_W-1:alu_rx_pkg::DATA_W];
    assign operand_b = operand_store[alu_rx_pkg::DATA_W-1:0];

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            data_out_a <= '0;
            data_out_b <= '0;
            opcode     <= '0;
        end
        else if (publish)
        begin
            data_out_a <= operand_a;
            data_out_b <= operand_b;
            opcode     <= payload.cmd.opcode;
        end
    end

endmodule

`default_nettype wire

// File: dv/alu_rx_model.svh
`ifndef ALU_RX_MODEL_SVH
`define ALU_RX_MODEL_SVH

////////////////////////////////////////
// Random source
////////////////////////////////////////

logic [31:0] lfsr_state = LFSR_SEED;

// Galois LFSR stepped once for every bit handed out
function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < width; i++)
    begin
        value = {value[30:0], lfsr_state[0]};
        if (lfsr_state[0])
        begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        end
        else
        begin
            lfsr_state = lfsr_state >> 1;
        end
    end
    return value;
endfunction

////////////////////////////////////////
// Reference CRC
////////////////////////////////////////

// Remainder of the message times x^4 divided by x^4 + x + 1
function automatic logic [3:0] crc_ref(input logic [31:0] a, input logic [31:0] b,
                                       input logic [2:0] op);
    logic [71:0] work;
    work = {a, b, 1'b1, op, 4'b0000};
    for (int i = 71; i >= 4; i--)
    begin
        if (work[i])
        begin
            work[i -: 5] = work[i -: 5] ^ 5'b1_0011;
        end
    end
    return work[3:0];
endfunction

// Byte idx of the operand pair, A first and MSB first
function automatic logic [7:0] byte_of(input logic [63:0] ab, input int idx);
    return ab[63 - 8 * idx -: 8];
endfunction

////////////////////////////////////////
// Line serialiser
////////////////////////////////////////

// Entered and left 2 ns after a rising edge
task automatic send_bit(input logic value);
    serial_in = value;
    repeat (16) @(posedge clk);
    #2;
endtask

task automatic send_idle(input int bits);
    for (int i = 0; i < bits; i++)
    begin
        send_bit(1'b1);
    end
endtask

task automatic send_frame(input logic type_bit, input logic [7:0] payload,
                          input logic stop_bit);
    send_bit(1'b0);
    send_bit(type_bit);
    for (int i = 7; i >= 0; i--)
    begin
        send_bit(payload[i]);
    end
    send_bit(stop_bit);
endtask

task automatic send_data_frames(input logic [63:0] ab, input int count);
    for (int f = 0; f < count; f++)
    begin
        send_frame(1'b0, byte_of(ab, f), 1'b1);
    end
endtask

task automatic send_packet(input logic [31:0] a, input logic [31:0] b, input logic [2:0] op,
                           input logic [3:0] crc, input logic flag);
    send_data_frames({a, b}, 8);
    send_frame(1'b1, {flag, op, crc}, 1'b1);
endtask

`endif

// File: dv/alu_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module alu_rx_tb;

    localparam logic [31:0] LFSR_SEED = 32'h0807_ceff;
    localparam int VALID_PKTS  = 10;
    localparam int CRC_PKTS    = 4;
    localparam int STOP_PKTS   = 4;
    localparam int TYPE_PKTS   = 4;
    localparam int GLITCH_RUNS = 3;
    // Every error run and glitch run is followed by a good packet
    localparam int PACKET_COUNT   = VALID_PKTS + CRC_PKTS
                                  + 2 * (STOP_PKTS + TYPE_PKTS + GLITCH_RUNS);
    localparam int TIMEOUT_CYCLES = PACKET_COUNT * 9 * 11 * 16 * 2;
    localparam int PULSE_WAIT     = 40;

    localparam int ACK       = 0;
    localparam int FRAME_ERR = 1;
    localparam int CRC_ERR   = 2;
    localparam int NO_PULSE  = -1;

    logic        clk;
    logic        rst;
    logic        serial_in;
    logic [31:0] data_out_a;
    logic [31:0] data_out_b;
    logic [2:0]  opcode;
    logic        ack;
    logic        frame_error;
    logic        crc_error;

    int          pulse_cnt [3];
    int          exp_cnt [3];
    int          cycle_cnt;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [2:0]  exp_op;

    `include "alu_rx_model.svh"

    alu_rx_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .serial_in   (serial_in),
        .data_out_a  (data_out_a),
        .data_out_b  (data_out_b),
        .opcode      (opcode),
        .ack         (ack),
        .frame_error (frame_error),
        .crc_error   (crc_error)
    );

    always #10 clk = ~clk;

    // Pulses are registered, so the falling edge sees each one once
    always @(negedge clk)
    begin
        if (ack)
            pulse_cnt[ACK]++;
        if (frame_error)
            pulse_cnt[FRAME_ERR]++;
        if (crc_error)
            pulse_cnt[CRC_ERR]++;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic string pulse_name(input int kind);
        case (kind)
            ACK:       return "ack";
            FRAME_ERR: return "frame_error";
            default:   return "crc_error";
        endcase
    endfunction

    task automatic check_outputs();
        assert (data_out_a === exp_a)
        else
        begin
            $display("ERR data_out_a got %h expected %h", data_out_a, exp_a);
            abort_run();
        end
        assert (data_out_b === exp_b)
        else
        begin
            $display("ERR data_out_b got %h expected %h", data_out_b, exp_b);
            abort_run();
        end
        assert (opcode === exp_op)
        else
        begin
            $display("ERR opcode got %h expected %h", opcode, exp_op);
            abort_run();
        end
    endtask

    // Wait for one pulse of the given kind, then compare every count and output
    task automatic await_outcome(input int kind);
        int waited;
        waited = 0;
        if (kind == NO_PULSE)
        begin
            repeat (PULSE_WAIT) @(posedge clk);
            #2;
        end
        else
        begin
            exp_cnt[kind]++;
            while (pulse_cnt[kind] < exp_cnt[kind] && waited < PULSE_WAIT)
            begin
                @(posedge clk);
                #2;
                waited++;
            end
            assert (pulse_cnt[kind] >= exp_cnt[kind])
            else
            begin
                $display("No %s pulse within %0d cycles", pulse_name(kind), PULSE_WAIT);
                abort_run();
            end
        end
        for (int i = 0; i < 3; i++)
        begin
            assert (pulse_cnt[i] == exp_cnt[i])
            else
            begin
                $display("Unexpected %s pulse, saw %0d in total where %0d were due",
                         pulse_name(i), pulse_cnt[i], exp_cnt[i]);
                abort_run();
            end
        end
        check_outputs();
    endtask

    task automatic run_valid_packet();
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  op;
        a  = rand_bits(32);
        b  = rand_bits(32);
        op = 3'(rand_bits(3));
        send_idle(2 + int'(rand_bits(2)));
        send_packet(a, b, op, crc_ref(a, b, op), 1'b0);
        exp_a  = a;
        exp_b  = b;
        exp_op = op;
        await_outcome(ACK);
    endtask

    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  op;
        logic [3:0]  crc_flip;
        int          pos;
        int          kind;
        int          len;
        clk       = 1'b0;
        rst       = 1'b0;
        serial_in = 1'b1;
        exp_a     = '0;
        exp_b     = '0;
        exp_op    = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        ////////////////////////////////////////
        // Idle after reset, then good packets
        ////////////////////////////////////////
        check_outputs();
        send_idle(4);
        await_outcome(NO_PULSE);
        repeat (VALID_PKTS) run_valid_packet();

        // Corrupted CRC must leave the outputs alone
        repeat (CRC_PKTS)
        begin
            a        = rand_bits(32);
            b        = rand_bits(32);
            op       = 3'(rand_bits(3));
            crc_flip = 4'(1 + rand_bits(8) % 15);
            send_idle(2 + int'(rand_bits(2)));
            send_packet(a, b, op, crc_ref(a, b, op) ^ crc_flip, 1'b0);
            await_outcome(CRC_ERR);
        end

        ////////////////////////////////////////
        // Frame errors
        ////////////////////////////////////////
        repeat (STOP_PKTS)
        begin
            a   = rand_bits(32);
            b   = rand_bits(32);
            op  = 3'(rand_bits(3));
            pos = int'(rand_bits(8) % 9);
            send_idle(2 + int'(rand_bits(2)));
            send_data_frames({a, b}, pos);
            if (pos < 8)
            begin
                send_frame(1'b0, byte_of({a, b}, pos), 1'b0);
            end
            else
            begin
                // Good CRC in the command frame so only the stop bit is wrong
                send_frame(1'b1, {1'b0, op, crc_ref(a, b, op)}, 1'b0);
            end
            send_idle(1);
            await_outcome(FRAME_ERR);
            run_valid_packet();
        end

        // All ones payload keeps the rest of a broken frame from faking a start
        repeat (TYPE_PKTS)
        begin
            a    = rand_bits(32);
            b    = rand_bits(32);
            op   = 3'(rand_bits(3));
            kind = int'(rand_bits(8) % 3);
            send_idle(2 + int'(rand_bits(2)));
            if (kind == 0)
            begin
                pos = int'(rand_bits(3));
                send_data_frames({a, b}, pos);
                send_frame(1'b1, 8'hff, 1'b1);
            end
            else if (kind == 1)
            begin
                send_data_frames({a, b}, 8);
                send_frame(1'b0, 8'hff, 1'b1);
            end
            else
            begin
                send_packet(a, b, op, crc_ref(a, b, op), 1'b1);
            end
            await_outcome(FRAME_ERR);
            run_valid_packet();
        end

        // Short low glitches on an idle line
        repeat (GLITCH_RUNS)
        begin
            len = 1 + int'(rand_bits(8) % 5);
            send_idle(2);
            serial_in = 1'b0;
            repeat (len) @(posedge clk);
            #2;
            serial_in = 1'b1;
            await_outcome(NO_PULSE);
            run_valid_packet();
        end

        send_idle(2);
        await_outcome(NO_PULSE);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
design/alu_rx_pkg.sv
design/rx_bit_timer.sv
design/rx_frame_ctrl.sv
design/rx_packet_assembler.sv
design/rx_crc4_check.sv
design/alu_rx_top.sv
dv/alu_rx_tb.sv
